/* common/caches_pkg.sv */
package caches_pkg;

  // cache geometry, one word per frame
  localparam int ICACHE_FRAMES = 16;

  // main memory size in words
  localparam int MEM_WORDS = 1024;

  // cycles from first sight of a request to completion, first cycle counts as one
  localparam int MEM_LATENCY = 3;

  // data word or byte address
  typedef logic [31:0] word_t;

  // address bits 31:6
  typedef logic [25:0] tag_t;

  // address bits 5:2, picks the frame
  typedef logic [3:0] idx_t;

  // byte within the word, ignored by the cache
  typedef logic [1:0] bytoff_t;

  // word address seen by main memory
  typedef logic [9:0] mem_addr_t;

  // byte address split into cache fields
  typedef struct packed {
    tag_t    tag;
    idx_t    idx;
    bytoff_t bytoff;
  } icachef_t;

  // one cache frame
  typedef struct packed {
    logic  valid;
    tag_t  tag;
    word_t data;
  } icache_frame;

endpackage

/* icache/icache.sv */
`timescale 1ns/10ps

module icache
  import caches_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  // fetch port from the datapath
  input  logic  imemREN,
  input  word_t imemaddr,
  output logic  ihit,
  output word_t imemload,
  // miss port toward the arbiter
  input  logic  iwait,
  input  word_t iload,
  input  logic  iload_done,
  output logic  iREN,
  output word_t iaddr
);

  typedef enum logic {
    idle = 1'b0,
    miss = 1'b1
  } icache_state_t;

  icachef_t icache_fmt;
  icache_frame [ICACHE_FRAMES-1:0] frames;
  icache_frame sel_frame;
  icache_state_t state;
  icache_state_t nxt_state;
  logic tag_match;
  logic fill;

  // split the fetch address into tag, index and offset
  assign icache_fmt = icachef_t'(imemaddr);

  // frame picked by the index bits
  assign sel_frame = frames[icache_fmt.idx];

  // valid frame with the same tag
  assign tag_match = sel_frame.valid && (sel_frame.tag == icache_fmt.tag);

  // hit is answered in the same cycle as the fetch
  assign ihit = imemREN && tag_match;

  // data is only meaningful while ihit is high
  assign imemload = sel_frame.data;

  // miss address only driven while the request is live
  assign iaddr = iREN ? imemaddr : '0;

  // idle/miss control
  always_comb begin
    nxt_state = state;
    iREN = 1'b0;
    fill = 1'b0;
    if (imemREN) begin
      // a miss seen in idle moves to miss on the next edge
      if (tag_match) begin
        nxt_state = idle;
      end else begin
        nxt_state = miss;
      end
      // only ask memory once we are sitting in miss
      if (state == miss && !tag_match) begin
        iREN = 1'b1;
        if (!iwait && iload_done) begin
          fill = 1'b1;
          nxt_state = idle;
        end
      end
    end
    // imemREN low abandons the request and keeps the state
  end

  // state and frame array
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= idle;
      // all frames invalid out of reset
      frames <= '0;
    end else begin
      state <= nxt_state;
      if (fill) begin
        frames[icache_fmt.idx] <= '{valid: 1'b1, tag: icache_fmt.tag, data: iload};
      end
    end
  end

  // hit only answers a live fetch
  a_hit_needs_ren: assert property (
    @(posedge CLK) disable iff (!nRST)
    ihit |-> imemREN
  );

endmodule

/* source/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter
  import caches_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  // external data port
  input  logic      dREN,
  input  logic      dWEN,
  input  word_t     daddr,
  input  word_t     dstore,
  output logic      dwait,
  output word_t     dload,
  // icache miss port
  input  logic      iREN,
  input  word_t     iaddr,
  output logic      iwait,
  output word_t     iload,
  output logic      iload_done,
  // memory port
  input  logic      ramwait,
  input  word_t     ramload,
  output logic      ramREN,
  output logic      ramWEN,
  output mem_addr_t ramaddr,
  output word_t     ramstore
);

  typedef enum logic [1:0] {
    g_none = 2'd0,
    g_data = 2'd1,
    g_inst = 2'd2
  } grant_t;

  grant_t grant;
  grant_t nxt_grant;
  grant_t owner;
  logic d_req;
  logic done;
  word_t sel_addr;

  // data side asks for either a read or a write
  assign d_req = dREN || dWEN;

  // owner of the memory port this cycle
  always_comb begin
    owner = g_none;
    case (grant)
      g_none: begin
        // free port lets data beat instruction
        if (d_req) begin
          owner = g_data;
        end else if (iREN) begin
          owner = g_inst;
        end
      end
      g_data: begin
        // a dropped request just releases the lock
        // memory sees one idle cycle and restarts its count
        if (d_req) begin
          owner = g_data;
        end
      end
      g_inst: begin
        if (iREN) begin
          owner = g_inst;
        end
      end
      default: owner = g_none;
    endcase
  end

  // memory finished the owner's access
  assign done = (owner != g_none) && !ramwait;

  // lock until completion
  assign nxt_grant = done ? g_none : owner;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      grant <= g_none;
    end else begin
      grant <= nxt_grant;
    end
  end

  // request mux onto memory
  assign ramREN = ((owner == g_data) && dREN) || (owner == g_inst);
  assign ramWEN = (owner == g_data) && dWEN;
  assign sel_addr = (owner == g_inst) ? iaddr : daddr;
  // byte address to word address
  assign ramaddr = sel_addr[$bits(mem_addr_t)+1:2];
  assign ramstore = dstore;

  // the side that does not own the port just waits
  assign dwait = !(done && (owner == g_data));
  assign iload_done = done && (owner == g_inst);
  assign iwait = !iload_done;

  // read data shared by both sides and valid on completion
  assign dload = ramload;
  assign iload = ramload;

  // at most one side completes per cycle
  a_one_done: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(!dwait && !iwait)
  );

  // instruction completion only for a live icache request
  a_idone_owner: assert property (
    @(posedge CLK) disable iff (!nRST)
    iload_done |-> (owner == g_inst) && iREN && (grant != g_data)
  );

endmodule

/* source/main_memory.sv */
`timescale 1ns/10ps

module main_memory
  import caches_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      ramREN,
  input  logic      ramWEN,
  input  mem_addr_t ramaddr,
  input  word_t     ramstore,
  output logic      ramwait,
  output word_t     ramload
);

  // storage with contents undefined until written
  word_t mem [MEM_WORDS];

  // cycles of the current request already seen
  logic [$clog2(MEM_LATENCY+1)-1:0] lat_cnt;
  logic req;
  logic done;

  assign req = ramREN || ramWEN;

  // completes on the MEM_LATENCY-th cycle of a steady request
  assign done = req && (lat_cnt == MEM_LATENCY - 1);

  // wait low only in the completing cycle
  assign ramwait = !done;

  // latency counter
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lat_cnt <= '0;
    end else if (!req || done) begin
      // dropped request or finished access starts over
      lat_cnt <= '0;
    end else begin
      lat_cnt <= lat_cnt + 1'b1;
    end
  end

  // write commits in the completing cycle
  always_ff @(posedge CLK) begin
    if (done && ramWEN) begin
      mem[ramaddr] <= ramstore;
    end
  end

  // read word taken by the requester when wait drops
  assign ramload = mem[ramaddr];

  // arbiter never forwards a read and a write together
  a_no_rw: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(ramREN && ramWEN)
  );

  // a stalled request is held steady by the arbiter
  a_hold_req: assert property (
    @(posedge CLK) disable iff (!nRST)
    (req && !done) ##1 req |-> $stable(ramaddr) && $stable(ramWEN)
  );

endmodule

/* source/ifetch_mem.sv */
`timescale 1ns/10ps

module ifetch_mem
  import caches_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  // instruction port
  input  logic  imemREN,
  input  word_t imemaddr,
  output logic  ihit,
  output word_t imemload,
  // data port
  input  logic  dREN,
  input  logic  dWEN,
  input  word_t daddr,
  input  word_t dstore,
  output logic  dwait,
  output word_t dload
);

  // icache to arbiter
  logic  iREN;
  word_t iaddr;
  logic  iwait;
  word_t iload;
  logic  iload_done;

  // arbiter to memory
  logic      ramREN;
  logic      ramWEN;
  mem_addr_t ramaddr;
  word_t     ramstore;
  logic      ramwait;
  word_t     ramload;

  // instruction cache, misses go through the arbiter
  icache u_icache (
    .CLK        (CLK),
    .nRST       (nRST),
    .imemREN    (imemREN),
    .imemaddr   (imemaddr),
    .ihit       (ihit),
    .imemload   (imemload),
    .iwait      (iwait),
    .iload      (iload),
    .iload_done (iload_done),
    .iREN       (iREN),
    .iaddr      (iaddr)
  );

  // data port has priority when the memory is free
  mem_arbiter u_mem_arbiter (
    .CLK        (CLK),
    .nRST       (nRST),
    .dREN       (dREN),
    .dWEN       (dWEN),
    .daddr      (daddr),
    .dstore     (dstore),
    .dwait      (dwait),
    .dload      (dload),
    .iREN       (iREN),
    .iaddr      (iaddr),
    .iwait      (iwait),
    .iload      (iload),
    .iload_done (iload_done),
    .ramwait    (ramwait),
    .ramload    (ramload),
    .ramREN     (ramREN),
    .ramWEN     (ramWEN),
    .ramaddr    (ramaddr),
    .ramstore   (ramstore)
  );

  // single-port memory with fixed latency
  main_memory u_main_memory (
    .CLK      (CLK),
    .nRST     (nRST),
    .ramREN   (ramREN),
    .ramWEN   (ramWEN),
    .ramaddr  (ramaddr),
    .ramstore (ramstore),
    .ramwait  (ramwait),
    .ramload  (ramload)
  );

endmodule

/* dv/ifetch_mem_tb.sv */
`timescale 1ns/10ps

module ifetch_mem_tb
  import caches_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 10;
  // one fetch address per frame plus a same-index partner each
  localparam int N_SET = 16;
  localparam int N_ROUNDS = 4;
  localparam int N_CONT = 8;
  // every data access and fetch issued over all tests
  localparam int N_REQ = 4 * N_SET + 2 + 2 * N_ROUNDS + 3 * N_CONT + 4 + 1;
  localparam int CYCLE_LIMIT = N_REQ * (MEM_LATENCY + 4) * 2;

  logic  CLK;
  logic  nRST;
  logic  imemREN;
  word_t imemaddr;
  logic  ihit;
  word_t imemload;
  logic  dREN;
  logic  dWEN;
  word_t daddr;
  word_t dstore;
  logic  dwait;
  word_t dload;

  // reference model state
  word_t shadow_mem [MEM_WORDS];
  logic  shadow_valid [ICACHE_FRAMES];
  tag_t  shadow_tag [ICACHE_FRAMES];
  word_t shadow_data [ICACHE_FRAMES];

  word_t pset [N_SET];
  word_t qset [N_SET];
  word_t cont_addr [N_CONT];
  word_t rng_state = 32'd91351;
  // no fetch traffic, so a data access sees the bare memory latency
  logic lone_data = 1'b0;
  int errors = 0;
  int checks = 0;
  int test_errors = 0;
  int cycles = 0;

  initial begin
    CLK = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) CLK = ~CLK;
    end
  end

  ifetch_mem u_ifetch_mem (
    .CLK      (CLK),
    .nRST     (nRST),
    .imemREN  (imemREN),
    .imemaddr (imemaddr),
    .ihit     (ihit),
    .imemload (imemload),
    .dREN     (dREN),
    .dWEN     (dWEN),
    .daddr    (daddr),
    .dstore   (dstore),
    .dwait    (dwait),
    .dload    (dload)
  );

  // xorshift32 step
  function automatic word_t next_rand();
    word_t x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // model says the frame holds this address
  function automatic logic ref_hit(input word_t a);
    idx_t idx;
    idx = a[5:2];
    return shadow_valid[idx] && (shadow_tag[idx] == a[31:6]);
  endfunction

  // expected fetch word where a cached copy stays stale after data writes
  function automatic word_t ref_fetch(input word_t a);
    if (ref_hit(a)) begin
      return shadow_data[a[5:2]];
    end
    // word address is byte address bits 11:2
    return shadow_mem[a[11:2]];
  endfunction

  task automatic check_eq(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %-16s finished, %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  // hold a fetch until ihit and return whether the first cycle hit
  task automatic fetch(input word_t a, output logic hit0);
    logic exp_hit;
    @(posedge CLK);
    exp_hit = ref_hit(a);
    imemREN <= 1'b1;
    imemaddr <= a;
    @(negedge CLK);
    hit0 = ihit;
    check_eq(ihit, exp_hit, "first-cycle ihit");
    while (!ihit) begin
      @(negedge CLK);
    end
    @(posedge CLK);
    imemREN <= 1'b0;
  endtask

  // one data read or write held until dwait drops
  task automatic data_access(input logic wr, input word_t a, input word_t wdata);
    int waited;
    @(posedge CLK);
    dREN <= !wr;
    dWEN <= wr;
    daddr <= a;
    dstore <= wdata;
    @(negedge CLK);
    waited = 1;
    while (dwait) begin
      @(negedge CLK);
      waited++;
    end
    if (lone_data) begin
      check_eq(waited, MEM_LATENCY, "data latency");
    end
    if (wr) begin
      shadow_mem[a[11:2]] = wdata;
    end else begin
      check_eq(dload, shadow_mem[a[11:2]], "dload");
    end
    @(posedge CLK);
    dREN <= 1'b0;
    dWEN <= 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge CLK);
    nRST <= 1'b0;
    for (int i = 0; i < ICACHE_FRAMES; i++) begin
      shadow_valid[i] = 1'b0;
    end
    repeat (RESET_CYCLES) @(posedge CLK);
    nRST <= 1'b1;
  endtask

  // fetch checker where the first hit after a miss marks a fill in the model
  always @(negedge CLK) begin
    if (nRST && ihit) begin
      if (!ref_hit(imemaddr)) begin
        shadow_valid[imemaddr[5:2]] = 1'b1;
        shadow_tag[imemaddr[5:2]] = imemaddr[31:6];
        shadow_data[imemaddr[5:2]] = shadow_mem[imemaddr[11:2]];
      end
      check_eq(imemload, ref_fetch(imemaddr), "imemload");
    end
  end

  // watchdog
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: tests still running after %0d cycles", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    logic hit;
    word_t r;
    nRST = 1'b0;
    imemREN = 1'b0;
    imemaddr = '0;
    dREN = 1'b0;
    dWEN = 1'b0;
    daddr = '0;
    dstore = '0;
    for (int i = 0; i < ICACHE_FRAMES; i++) begin
      shadow_valid[i] = 1'b0;
    end
    repeat (RESET_CYCLES) @(posedge CLK);
    nRST <= 1'b1;

    // lower half of memory for fetches with the partner flipping tag bit 6
    for (int i = 0; i < N_SET; i++) begin
      r = next_rand();
      pset[i] = {20'h0, 1'b0, r[10:6], idx_t'(i), 2'b00};
      qset[i] = pset[i] ^ 32'h40;
    end
    lone_data = 1'b1;
    for (int i = 0; i < N_SET; i++) begin
      data_access(1'b1, pset[i], next_rand());
      data_access(1'b1, qset[i], next_rand());
    end
    for (int i = 0; i < N_SET; i++) begin
      data_access(1'b0, pset[i], '0);
      data_access(1'b0, qset[i], '0);
    end
    lone_data = 1'b0;
    end_test("data path");

    fetch(pset[0], hit);
    check_eq(hit, 1'b0, "cold fetch hit");
    fetch(pset[0], hit);
    check_eq(hit, 1'b1, "repeat fetch hit");
    end_test("cold fill");

    // same index and different tags so every fetch misses
    for (int k = 0; k < N_ROUNDS; k++) begin
      fetch(pset[1], hit);
      fetch(qset[1], hit);
    end
    end_test("conflict");

    // upper half is data only and never fetched
    for (int i = 0; i < N_CONT; i++) begin
      r = next_rand();
      cont_addr[i] = {20'h0, 1'b1, r[10:2], 2'b00};
    end
    fork
      begin
        for (int i = 0; i < N_CONT; i++) begin
          fetch(pset[2 + i], hit);
        end
      end
      begin
        for (int i = 0; i < N_CONT; i++) begin
          data_access(1'b1, cont_addr[i], next_rand());
        end
        for (int i = 0; i < N_CONT; i++) begin
          data_access(1'b0, cont_addr[i], '0);
        end
      end
    join
    end_test("contention");

    // new value always differs from the cached one
    data_access(1'b1, pset[0], shadow_mem[pset[0][11:2]] ^ (next_rand() | 32'h1));
    fetch(pset[0], hit);
    check_eq(hit, 1'b1, "stale fetch hit");
    fetch(qset[0], hit);
    fetch(pset[0], hit);
    check_eq(hit, 1'b0, "refetch after eviction hit");
    end_test("stale hit");

    apply_reset();
    fetch(pset[2], hit);
    check_eq(hit, 1'b0, "fetch after reset hit");
    end_test("reset");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* ifetch_mem.f */
common/caches_pkg.sv
icache/icache.sv
source/mem_arbiter.sv
source/main_memory.sv
source/ifetch_mem.sv
dv/ifetch_mem_tb.sv

/* Bender.yml */
package:
  name: ifetch_mem

sources:
  - common/caches_pkg.sv
  - icache/icache.sv
  - source/mem_arbiter.sv
  - source/main_memory.sv
  - source/ifetch_mem.sv
  - target: test
    files:
      - dv/ifetch_mem_tb.sv
